/* src/attr_pkg.sv */
`default_nettype none

package attr_pkg;

    ////////////////////////////////////////
    // Widths and pipeline shape
    ////////////////////////////////////////

    // One attribute word in signed fixed point
    localparam int ATTR_W = 32;

    // Screen coordinates are unsigned
    localparam int POS_W = 16;

    localparam int FB_INDEX_W = 32;

    // tex_s, tex_t, depth_z, color_r, color_g, color_b, color_a
    localparam int NUM_ATTRS = 7;

    // Register stages from an accepted pixel to the output
    localparam int INTERP_LATENCY = 3;

    // Enough bits to count every pixel that can be in flight
    localparam int PIXEL_CNT_W = $clog2(INTERP_LATENCY + 1);

    ////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////

    // Base, increment or result of one channel
    typedef logic signed [ATTR_W-1:0] attr_t;

    // Index 0 is tex_s up to index 6 for color_a
    typedef attr_t [NUM_ATTRS-1:0] attr_vec_t;

    typedef logic [POS_W-1:0] screen_pos_t;

    typedef logic [FB_INDEX_W-1:0] fb_index_t;

    // Stream control that travels alongside the datapath
    typedef struct packed {
        logic valid;
        logic last;
    } stream_flags_t;

endpackage

`default_nettype wire

/* src/stage_delay.sv */
`default_nettype none

module stage_delay import attr_pkg::*; #(
    parameter type payload_t = stream_flags_t,
    parameter int  DEPTH     = INTERP_LATENCY
) (
    input  wire      aclk,
    input  wire      arst_n,
    input  wire      advance,
    input  payload_t in,
    output payload_t out
);

    // Shift register, entry 0 is the newest value
    payload_t pipe [DEPTH];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else if (advance) begin
            // Bubbles shift along with real entries
            pipe[0] <= in;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign out = pipe[DEPTH-1];

endmodule

`default_nettype wire

/* src/plane_eval.sv */
`default_nettype none

module plane_eval import attr_pkg::*; (
    input  wire         aclk,
    input  wire         arst_n,
    input  wire         advance,
    input  screen_pos_t pos_x,
    input  screen_pos_t pos_y,
    input  attr_t       base,
    input  attr_t       inc_x,
    input  attr_t       inc_y,
    output attr_t       result
);

    // Coordinates widened to attribute width, always non-negative
    attr_t pos_x_ext;
    attr_t pos_y_ext;

    // Stage 1
    attr_t prod_x_s1;
    attr_t prod_y_s1;
    attr_t base_s1;

    // Stage 2
    attr_t prod_sum_s2;
    attr_t base_s2;

    assign pos_x_ext = {{(ATTR_W - POS_W){1'b0}}, pos_x};
    assign pos_y_ext = {{(ATTR_W - POS_W){1'b0}}, pos_y};

    ////////////////////////////////////////
    // Stage 1 multiply
    ////////////////////////////////////////

    // Only the low 32 bits of each product are kept
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            prod_x_s1 <= '0;
            prod_y_s1 <= '0;
            base_s1   <= '0;
        end else if (advance) begin
            prod_x_s1 <= inc_x * pos_x_ext;
            prod_y_s1 <= inc_y * pos_y_ext;
            base_s1   <= base;
        end
    end

    ////////////////////////////////////////
    // Stage 2 and 3 accumulate
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            prod_sum_s2 <= '0;
            base_s2     <= '0;
        end else if (advance) begin
            prod_sum_s2 <= prod_x_s1 + prod_y_s1;
            base_s2     <= base_s1;
        end
    end

    // Final sum wraps modulo 2^32
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (advance) begin
            result <= prod_sum_s2 + base_s2;
        end
    end

endmodule

`default_nettype wire

/* src/interp_ctrl.sv */
`default_nettype none

module interp_ctrl import attr_pkg::*; (
    input  wire  aclk,
    input  wire  arst_n,
    input  wire  s_tvalid,
    input  wire  s_tlast,
    output logic s_tready,
    input  wire  m_tready,
    output logic m_tvalid,
    output logic m_tlast,
    output logic advance,
    output logic pixel_in_pipeline
);

    stream_flags_t flags_in;
    stream_flags_t flags_out;

    logic accept;
    logic deliver;

    // Accepted pixels that have not been delivered yet
    logic [PIXEL_CNT_W-1:0] pixel_cnt;

    ////////////////////////////////////////
    // Handshake and stall
    ////////////////////////////////////////

    // Hold everything while the output is waiting on downstream
    assign advance  = !(m_tvalid && !m_tready);
    assign s_tready = advance;

    assign accept  = s_tvalid && s_tready;
    assign deliver = m_tvalid && m_tready;

    // An idle input cycle enters the chain as a bubble
    assign flags_in.valid = s_tvalid;
    assign flags_in.last  = s_tvalid && s_tlast;

    stage_delay #(
        .payload_t (stream_flags_t),
        .DEPTH     (INTERP_LATENCY)
    ) flag_delay_i (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .advance (advance),
        .in      (flags_in),
        .out     (flags_out)
    );

    assign m_tvalid = flags_out.valid;
    assign m_tlast  = flags_out.last;

    ////////////////////////////////////////
    // Pixel tracking
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pixel_cnt <= '0;
        end else begin
            case ({accept, deliver})
                2'b10:   pixel_cnt <= pixel_cnt + 1'b1;
                2'b01:   pixel_cnt <= pixel_cnt - 1'b1;
                // Accept and delivery together leave the count unchanged
                default: pixel_cnt <= pixel_cnt;
            endcase
        end
    end

    assign pixel_in_pipeline = (pixel_cnt != '0);

endmodule

`default_nettype wire

/* src/attr_interp_top.sv */
`default_nettype none

module attr_interp_top import attr_pkg::*; (
    input  wire         aclk,
    input  wire         arst_n,

    // Pixel stream in
    input  wire         s_tvalid,
    output logic        s_tready,
    input  wire         s_tlast,
    input  screen_pos_t s_pos_x,
    input  screen_pos_t s_pos_y,
    input  fb_index_t   s_fb_index,

    // Interpolated pixel stream out
    output logic        m_tvalid,
    input  wire         m_tready,
    output logic        m_tlast,
    output fb_index_t   m_fb_index,
    output attr_vec_t   m_attr,

    // Plane coefficients, held steady while pixels are in flight
    input  attr_vec_t   attr_base,
    input  attr_vec_t   attr_inc_x,
    input  attr_vec_t   attr_inc_y,

    output logic        pixel_in_pipeline
);

    // Common enable for every pipeline register
    logic advance;

    ////////////////////////////////////////
    // Stream control
    ////////////////////////////////////////

    interp_ctrl ctrl_i (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .s_tvalid          (s_tvalid),
        .s_tlast           (s_tlast),
        .s_tready          (s_tready),
        .m_tready          (m_tready),
        .m_tvalid          (m_tvalid),
        .m_tlast           (m_tlast),
        .advance           (advance),
        .pixel_in_pipeline (pixel_in_pipeline)
    );

    // Framebuffer index rides along with the attribute math
    stage_delay #(
        .payload_t (fb_index_t),
        .DEPTH     (INTERP_LATENCY)
    ) fb_delay_i (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .advance (advance),
        .in      (s_fb_index),
        .out     (m_fb_index)
    );

    ////////////////////////////////////////
    // Attribute channels
    ////////////////////////////////////////

    for (genvar ch = 0; ch < NUM_ATTRS; ch++) begin : g_channel
        plane_eval plane_eval_i (
            .aclk    (aclk),
            .arst_n  (arst_n),
            .advance (advance),
            .pos_x   (s_pos_x),
            .pos_y   (s_pos_y),
            .base    (attr_base[ch]),
            .inc_x   (attr_inc_x[ch]),
            .inc_y   (attr_inc_y[ch]),
            .result  (m_attr[ch])
        );
    end

endmodule

`default_nettype wire

/* tests/attr_interp_checker.sv */
`default_nettype none

module attr_interp_checker import attr_pkg::*; (
    input  wire       aclk,
    input  wire       arst_n,
    input  wire       s_tvalid,
    input  wire       s_tready,
    input  wire       s_tlast,
    input  fb_index_t s_fb_index,
    input  attr_vec_t exp_attr,
    input  wire       m_tvalid,
    input  wire       m_tready,
    input  wire       m_tlast,
    input  fb_index_t m_fb_index,
    input  attr_vec_t m_attr,
    input  wire       pixel_in_pipeline,
    input  wire       final_check,
    output int        mismatch_count,
    output int        protocol_count
);

    // Accepted pixels still waiting for their delivery, oldest first
    attr_vec_t attr_q[$];
    fb_index_t index_q[$];
    logic      last_q[$];
    int        cycle_q[$];
    int        stall_q[$];

    int        cycle;
    int        stall_total;
    logic      want_ready;
    logic      want_busy;
    logic      was_stalled;
    logic      held_last;
    fb_index_t held_index;
    attr_vec_t held_attr;
    logic      final_done;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, want);
        mismatch_count++;
    endtask

    // Compares one delivered pixel with the oldest accepted one
    task automatic check_delivery();
        attr_vec_t want_attr;
        fb_index_t want_index;
        logic      want_last;
        int        edges;
        int        want_edges;
        if (index_q.size() == 0) begin
            $display("Error at time %0t: a pixel was delivered but none was waiting", $time);
            protocol_count++;
        end else begin
            want_attr  = attr_q.pop_front();
            want_index = index_q.pop_front();
            want_last  = last_q.pop_front();
            edges      = cycle - cycle_q.pop_front();
            // Every stalled edge in between adds one edge of delay
            want_edges = INTERP_LATENCY + stall_total - stall_q.pop_front();
            for (int ch = 0; ch < NUM_ATTRS; ch++) begin
                if (m_attr[ch] !== want_attr[ch]) begin
                    report_mismatch($sformatf("m_attr[%0d]", ch), m_attr[ch], want_attr[ch]);
                end
            end
            if (m_fb_index !== want_index) begin
                report_mismatch("m_fb_index", m_fb_index, want_index);
            end
            if (m_tlast !== want_last) begin
                report_mismatch("m_tlast", 32'(m_tlast), 32'(want_last));
            end
            if (edges != want_edges) begin
                $display("Error at time %0t: pixel %h came out after %0d edges instead of %0d",
                         $time, want_index, edges, want_edges);
                protocol_count++;
            end
        end
    endtask

    ////////////////////////////////////////
    // Sampling at mid-cycle
    ////////////////////////////////////////

    always @(negedge aclk) begin
        if (!arst_n) begin
            attr_q.delete();
            index_q.delete();
            last_q.delete();
            cycle_q.delete();
            stall_q.delete();
            cycle          = 0;
            stall_total    = 0;
            was_stalled    = 1'b0;
            final_done     = 1'b0;
            mismatch_count = 0;
            protocol_count = 0;
        end else begin
            cycle++;
            want_ready = !(m_tvalid && !m_tready);
            want_busy  = (index_q.size() != 0);
            if (s_tready !== want_ready) begin
                report_mismatch("s_tready", 32'(s_tready), 32'(want_ready));
            end
            if (pixel_in_pipeline !== want_busy) begin
                report_mismatch("pixel_in_pipeline", 32'(pixel_in_pipeline), 32'(want_busy));
            end

            // A held output must not move while downstream is not ready
            if (was_stalled) begin
                if (m_tvalid !== 1'b1) begin
                    report_mismatch("m_tvalid", 32'(m_tvalid), 32'(1'b1));
                end
                if (m_tlast !== held_last) begin
                    report_mismatch("m_tlast", 32'(m_tlast), 32'(held_last));
                end
                if (m_fb_index !== held_index) begin
                    report_mismatch("m_fb_index", m_fb_index, held_index);
                end
                for (int ch = 0; ch < NUM_ATTRS; ch++) begin
                    if (m_attr[ch] !== held_attr[ch]) begin
                        report_mismatch($sformatf("m_attr[%0d]", ch), m_attr[ch], held_attr[ch]);
                    end
                end
            end

            if (m_tvalid && m_tready) begin
                check_delivery();
            end
            if (s_tvalid && s_tready) begin
                attr_q.push_back(exp_attr);
                index_q.push_back(s_fb_index);
                last_q.push_back(s_tlast);
                cycle_q.push_back(cycle);
                stall_q.push_back(stall_total);
            end

            was_stalled = m_tvalid && !m_tready;
            if (was_stalled) begin
                stall_total++;
            end
            held_last  = m_tlast;
            held_index = m_fb_index;
            held_attr  = m_attr;

            if (final_check && !final_done) begin
                final_done = 1'b1;
                if (index_q.size() != 0) begin
                    $display("Error at time %0t: %0d accepted pixels were never delivered",
                             $time, index_q.size());
                    protocol_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tests/attr_interp_tb.sv */
`default_nettype none

module attr_interp_tb import attr_pkg::*; ();

    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_BURSTS = 5;

    logic        aclk;
    logic        arst_n;
    logic        s_tvalid;
    logic        s_tready;
    logic        s_tlast;
    screen_pos_t s_pos_x;
    screen_pos_t s_pos_y;
    fb_index_t   s_fb_index;
    logic        m_tvalid;
    logic        m_tready;
    logic        m_tlast;
    fb_index_t   m_fb_index;
    attr_vec_t   m_attr;
    attr_vec_t   attr_base;
    attr_vec_t   attr_inc_x;
    attr_vec_t   attr_inc_y;
    logic        pixel_in_pipeline;

    attr_vec_t   exp_attr;
    logic        final_check;
    int          mismatch_count;
    int          protocol_count;
    int          timeout_count;
    int          seed;
    logic        ready_random;
    fb_index_t   next_index;

    // Plane value from exact integer math cut to the low 32 bits
    function automatic attr_t expected_attr(input screen_pos_t x, input screen_pos_t y,
                                            input attr_t base, input attr_t inc_x,
                                            input attr_t inc_y);
        longint sum;
        sum = longint'(base) + longint'(inc_x) * longint'(x) + longint'(inc_y) * longint'(y);
        return sum[31:0];
    endfunction

    always_comb begin
        for (int ch = 0; ch < NUM_ATTRS; ch++) begin
            exp_attr[ch] = expected_attr(s_pos_x, s_pos_y, attr_base[ch], attr_inc_x[ch],
                                         attr_inc_y[ch]);
        end
    end

    attr_interp_top dut_i (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .s_tvalid          (s_tvalid),
        .s_tready          (s_tready),
        .s_tlast           (s_tlast),
        .s_pos_x           (s_pos_x),
        .s_pos_y           (s_pos_y),
        .s_fb_index        (s_fb_index),
        .m_tvalid          (m_tvalid),
        .m_tready          (m_tready),
        .m_tlast           (m_tlast),
        .m_fb_index        (m_fb_index),
        .m_attr            (m_attr),
        .attr_base         (attr_base),
        .attr_inc_x        (attr_inc_x),
        .attr_inc_y        (attr_inc_y),
        .pixel_in_pipeline (pixel_in_pipeline)
    );

    attr_interp_checker checker_i (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .s_tvalid          (s_tvalid),
        .s_tready          (s_tready),
        .s_tlast           (s_tlast),
        .s_fb_index        (s_fb_index),
        .exp_attr          (exp_attr),
        .m_tvalid          (m_tvalid),
        .m_tready          (m_tready),
        .m_tlast           (m_tlast),
        .m_fb_index        (m_fb_index),
        .m_attr            (m_attr),
        .pixel_in_pipeline (pixel_in_pipeline),
        .final_check       (final_check),
        .mismatch_count    (mismatch_count),
        .protocol_count    (protocol_count)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #20 aclk = ~aclk;
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    task automatic finish_run();
        $display("Checks done: %0d mismatches, %0d protocol errors, %0d timeouts",
                 mismatch_count, protocol_count, timeout_count);
        if (mismatch_count + protocol_count + timeout_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at time %0t: gave up waiting for %s", $time, what);
        timeout_count++;
    endtask

    // One rising edge and a fresh downstream ready for the next cycle
    task automatic tick();
        int r;
        @(posedge aclk);
        r = $random(seed);
        if (ready_random) begin
            m_tready <= r[0];
        end else begin
            m_tready <= 1'b1;
        end
    endtask

    // Corner coordinates come up about half the time
    task automatic pick_coord(output screen_pos_t pos);
        int r;
        r = $random(seed);
        case (r[1:0])
            2'd0:    pos = '0;
            2'd1:    pos = '1;
            default: pos = r[31:16];
        endcase
    endtask

    task automatic load_coefficients();
        int r;
        for (int ch = 0; ch < NUM_ATTRS; ch++) begin
            r = $random(seed);
            attr_base[ch] <= $random(seed);
            if (r[0]) begin
                attr_inc_x[ch] <= $random(seed) % 4096;
                attr_inc_y[ch] <= $random(seed) % 4096;
            end else begin
                attr_inc_x[ch] <= $random(seed);
                attr_inc_y[ch] <= $random(seed);
            end
        end
    endtask

    task automatic send_pixel(input screen_pos_t x, input screen_pos_t y, input logic last);
        int waited;
        s_tvalid   <= 1'b1;
        s_tlast    <= last;
        s_pos_x    <= x;
        s_pos_y    <= y;
        s_fb_index <= next_index;
        next_index = next_index + 1;
        waited = 0;
        // Accepted on the first edge that sees s_tready high
        do begin
            tick();
            waited++;
        end while (!s_tready && waited < WAIT_LIMIT);
        if (!s_tready) begin
            report_timeout("an input accept");
        end
    endtask

    task automatic send_burst(input int len, input logic with_gaps);
        screen_pos_t x;
        screen_pos_t y;
        int          r;
        for (int i = 0; i < len && timeout_count == 0; i++) begin
            pick_coord(x);
            pick_coord(y);
            send_pixel(x, y, i == len - 1);
            r = $random(seed);
            if (with_gaps && r[1:0] == 2'b00) begin
                s_tvalid <= 1'b0;
                repeat (r[3:2] + 1) tick();
            end
        end
        s_tvalid <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        tick();
        while (pixel_in_pipeline && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (pixel_in_pipeline) begin
            report_timeout("the pipeline to drain");
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        seed          = 10;
        arst_n        = 1'b0;
        s_tvalid      = 1'b0;
        s_tlast       = 1'b0;
        s_pos_x       = '0;
        s_pos_y       = '0;
        s_fb_index    = '0;
        m_tready      = 1'b1;
        attr_base     = '0;
        attr_inc_x    = '0;
        attr_inc_y    = '0;
        final_check   = 1'b0;
        timeout_count = 0;
        ready_random  = 1'b0;
        next_index    = 32'h0000_1000;
        repeat (3) @(posedge aclk);
        arst_n <= 1'b1;

        // First burst runs back to back with downstream always ready
        for (int b = 0; b < NUM_BURSTS && timeout_count == 0; b++) begin
            ready_random = (b != 0);
            load_coefficients();
            send_burst(8 + 6 * b, b >= 2);
            if (timeout_count == 0) begin
                wait_drain();
            end
        end

        final_check <= 1'b1;
        tick();
        tick();
        finish_run();
    end

endmodule

`default_nettype wire

/* attr_interp.f */
src/attr_pkg.sv
src/stage_delay.sv
src/plane_eval.sv
src/interp_ctrl.sv
src/attr_interp_top.sv
tests/attr_interp_checker.sv
tests/attr_interp_tb.sv

/* Makefile */
# Verilator build and run for the attribute interpolator

VERILATOR ?= verilator
TOP       ?= attr_interp_tb
FILELIST  ?= attr_interp.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

# Passes only when the simulation prints the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(BUILD_DIR)
